// File: frontend_top.f
hdl/frontend_pkg.sv
hdl/next_block_gen.sv
hdl/ftq.sv
hdl/fetch_unit.sv
hdl/frontend_top.sv
tb/tb_frontend_top.sv

// File: Makefile
# Verilator build for the fetch frontend

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f frontend_top.f --top-module frontend_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f frontend_top.f \
		--top-module tb_frontend_top -Mdir obj_dir -o sim_frontend_top
	./obj_dir/sim_frontend_top > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_frontend_top.sv
`timescale 1ns/100ps

module tb_frontend_top;

    import frontend_pkg::*;

    localparam int OP_RUN     = 0;
    localparam int OP_STALL   = 1;
    localparam int OP_FLUSH   = 2;
    localparam int RDY_ALWAYS = 0;
    localparam int RDY_RANDOM = 1;
    localparam int NROWS      = 10;

    logic                    clk;
    logic                    rst;
    logic                    flush;
    logic [FTQ_ID_W-1:0]     flush_id;
    logic [PC_W-1:0]         redirect_pc;
    logic [COMMIT_WIDTH-1:0] commit;
    logic                    inst_ready;
    logic                    inst_valid;
    logic [PC_W-1:0]         inst_pc;
    logic [FTQ_ID_W-1:0]     inst_ftq_id;
    logic                    inst_cross;

    // Stimulus table with one row per test
    int                      op_tbl   [NROWS];
    int                      cyc_tbl  [NROWS];
    logic [PC_W-1:0]         pc_tbl   [NROWS];
    logic [FTQ_ID_W-1:0]     id_tbl   [NROWS];
    logic [COMMIT_WIDTH-1:0] cm_tbl   [NROWS];
    int                      rdy_tbl  [NROWS];
    string                   name_tbl [NROWS];

    // Reference model of the delivered PC stream
    logic [PC_W-1:0]     exp_pc;
    logic [PC_W-1:0]     blk_end;
    logic [FTQ_ID_W-1:0] cur_id;
    logic [FTQ_ID_W-1:0] next_id;
    logic                cur_cross;
    int                  cur_len;

    // Blocks up to lim_ptr may be retired
    logic [FTQ_ID_W-1:0] comm_ptr;
    logic [FTQ_ID_W-1:0] lim_ptr;

    logic                hold_q;
    logic [PC_W-1:0]     hold_pc;
    logic [FTQ_ID_W-1:0] hold_id;

    integer seed;
    int     errors;
    int     checks;
    int     row_got;
    int     row_err;
    int     tests_failed;

    frontend_top u_dut (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush),
        .flush_ftq_id_i    (flush_id),
        .redirect_pc_i     (redirect_pc),
        .commit_i          (commit),
        .inst_ready_i      (inst_ready),
        .inst_valid_o      (inst_valid),
        .inst_pc_o         (inst_pc),
        .inst_ftq_id_o     (inst_ftq_id),
        .inst_cross_line_o (inst_cross)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic set_row(input int r, input string nm, input int op, input int cyc,
                           input logic [PC_W-1:0] pc, input logic [FTQ_ID_W-1:0] id,
                           input logic [COMMIT_WIDTH-1:0] cm, input int rdy);
        name_tbl[r] = nm;
        op_tbl[r]   = op;
        cyc_tbl[r]  = cyc;
        pc_tbl[r]   = pc;
        id_tbl[r]   = id;
        cm_tbl[r]   = cm;
        rdy_tbl[r]  = rdy;
    endtask

    // For flush and stall rows the cycle count is the timeout
    task automatic load_table();
        set_row(0, "seq_fetch",          OP_RUN,   60,  32'h0, 3'd0, 2'b11, RDY_ALWAYS);
        set_row(1, "queue_full_stall",   OP_STALL, 120, 32'h0, 3'd0, 2'b00, RDY_ALWAYS);
        set_row(2, "commit_resume",      OP_RUN,   60,  32'h0, 3'd0, 2'b01, RDY_ALWAYS);
        set_row(3, "redirect",           OP_FLUSH, 40,  32'h0000_4000, 3'd5, 2'b11, RDY_ALWAYS);
        set_row(4, "after_redirect",     OP_RUN,   50,  32'h0, 3'd0, 2'b11, RDY_ALWAYS);
        set_row(5, "decode_backpressure", OP_RUN,  200, 32'h0, 3'd0, 2'b11, RDY_RANDOM);
        set_row(6, "unaligned_redirect", OP_FLUSH, 60,  32'h0000_2018, 3'd2, 2'b11, RDY_RANDOM);
        set_row(7, "unaligned_run",      OP_RUN,   40,  32'h0, 3'd0, 2'b11, RDY_RANDOM);
        set_row(8, "line_cross_redirect", OP_FLUSH, 40, 32'h0000_300C, 3'd7, 2'b11, RDY_ALWAYS);
        set_row(9, "line_cross_run",     OP_RUN,   60,  32'h0, 3'd0, 2'b11, RDY_ALWAYS);
    endtask

    // Instructions left in the 32-byte window up to four
    function automatic int block_len(input logic [PC_W-1:0] pc);
        int slots;
        slots = (FETCH_WINDOW_BYTES - int'(pc & PC_W'(FETCH_WINDOW_BYTES - 1))) / 4;
        if (slots > FETCH_WIDTH) begin
            slots = FETCH_WIDTH;
        end
        return slots;
    endfunction

    function automatic logic crosses_line(input logic [PC_W-1:0] pc, input int len);
        logic [PC_W-1:0] last;
        last = pc + PC_W'(4 * (len - 1));
        return (pc / PC_W'(CACHELINE_BYTES)) != (last / PC_W'(CACHELINE_BYTES));
    endfunction

    task automatic report_mismatch(input string sig, input logic [PC_W-1:0] got,
                                   input logic [PC_W-1:0] exp);
        $display("ERROR t=%0t %s got 0x%h expected 0x%h", $time, sig, got, exp);
        errors++;
        row_err++;
    endtask

    task automatic report_failure(input string msg);
        $display("Check failed at t=%0t: %s", $time, msg);
        errors++;
        row_err++;
    endtask

    // Called at the rising edge, before new inputs are scheduled
    task automatic observe();
        logic [FTQ_ID_W-1:0] depth;
        if (flush) begin
            exp_pc  = redirect_pc;
            blk_end = redirect_pc;
            next_id = flush_id + FTQ_ID_W'(1);
            lim_ptr = next_id;
            hold_q  = 1'b0;
            row_got = 0;
        end else begin
            if (hold_q) begin
                checks++;
                if (inst_valid !== 1'b1) begin
                    report_failure("inst_valid_o dropped while decode was stalled");
                end else begin
                    if (inst_pc !== hold_pc) begin
                        report_mismatch("inst_pc_o (held)", inst_pc, hold_pc);
                    end
                    if (inst_ftq_id !== hold_id) begin
                        report_mismatch("inst_ftq_id_o (held)", PC_W'(inst_ftq_id),
                                        PC_W'(hold_id));
                    end
                end
            end
            if (inst_valid && inst_ready) begin
                if (exp_pc == blk_end) begin
                    cur_len   = block_len(exp_pc);
                    cur_cross = crosses_line(exp_pc, cur_len);
                    cur_id    = next_id;
                    next_id   = next_id + FTQ_ID_W'(1);
                    blk_end   = exp_pc + PC_W'(4 * cur_len);
                    depth     = cur_id - comm_ptr;
                    if (int'(depth) > FTQ_SIZE - 2) begin
                        report_failure("more blocks in flight than the queue can hold");
                    end
                end
                checks++;
                if (inst_pc !== exp_pc) begin
                    report_mismatch("inst_pc_o", inst_pc, exp_pc);
                end
                if (inst_ftq_id !== cur_id) begin
                    report_mismatch("inst_ftq_id_o", PC_W'(inst_ftq_id), PC_W'(cur_id));
                end
                if (inst_cross !== cur_cross) begin
                    report_mismatch("inst_cross_line_o", PC_W'(inst_cross), PC_W'(cur_cross));
                end
                exp_pc = exp_pc + PC_W'(4);
                row_got++;
                // Last PC of a block consumed, so the block may retire
                if (exp_pc == blk_end) begin
                    lim_ptr = cur_id + FTQ_ID_W'(1);
                end
            end
            hold_q  = inst_valid && !inst_ready;
            hold_pc = inst_pc;
            hold_id = inst_ftq_id;
        end
    endtask

    // Retire only blocks that decode has finished
    task automatic drive_cycle(input logic [COMMIT_WIDTH-1:0] mask, input int rdy_mode);
        logic [FTQ_ID_W-1:0]     pending;
        logic [COMMIT_WIDTH-1:0] cm;
        int                      n;
        pending = lim_ptr - comm_ptr;
        n = $countones(mask);
        if (n > int'(pending)) begin
            n = int'(pending);
        end
        cm = '0;
        for (int i = 0; i < n; i++) begin
            cm[i] = 1'b1;
        end
        comm_ptr = comm_ptr + FTQ_ID_W'(n);
        commit <= cm;
        flush  <= 1'b0;
        if (rdy_mode == RDY_RANDOM) begin
            inst_ready <= (($random(seed) & 3) != 0);
        end else begin
            inst_ready <= 1'b1;
        end
    endtask

    task automatic step_cycle(input int r);
        @(posedge clk);
        observe();
        drive_cycle(cm_tbl[r], rdy_tbl[r]);
    endtask

    task automatic run_row(input int r);
        int waited;
        int idle;
        row_got = 0;
        row_err = 0;
        waited  = 0;
        idle    = 0;
        case (op_tbl[r])
            OP_RUN: begin
                repeat (cyc_tbl[r]) begin
                    step_cycle(r);
                end
                if (row_got == 0) begin
                    report_failure("no instruction delivered during the test");
                end
            end
            OP_STALL: begin
                while (idle < 8 && waited < cyc_tbl[r]) begin
                    step_cycle(r);
                    idle = inst_valid ? 0 : idle + 1;
                    waited++;
                end
                if (idle < 8) begin
                    report_failure("delivery never stopped without commits");
                end else if (lim_ptr - comm_ptr != FTQ_ID_W'(FTQ_SIZE - 1)) begin
                    report_mismatch("outstanding blocks", PC_W'(FTQ_ID_W'(lim_ptr - comm_ptr)),
                                    PC_W'(FTQ_SIZE - 1));
                end
            end
            default: begin
                step_cycle(r);
                flush       <= 1'b1;
                flush_id    <= id_tbl[r];
                redirect_pc <= pc_tbl[r];
                // Wait for the first delivery after the redirect
                while ((row_got == 0 || flush) && waited < cyc_tbl[r]) begin
                    step_cycle(r);
                    waited++;
                end
                if (row_got == 0) begin
                    report_failure("no instruction delivered after the redirect");
                end
            end
        endcase
    endtask

    initial begin
        seed         = 40686;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        rst          = 1'b1;
        flush        = 1'b0;
        flush_id     = '0;
        redirect_pc  = '0;
        commit       = '0;
        inst_ready   = 1'b0;
        exp_pc       = RESET_PC;
        blk_end      = RESET_PC;
        next_id      = '0;
        cur_id       = '0;
        cur_cross    = 1'b0;
        cur_len      = 0;
        comm_ptr     = '0;
        lim_ptr      = '0;
        hold_q       = 1'b0;
        hold_pc      = '0;
        hold_id      = '0;
        load_table();

        repeat (4) @(posedge clk);
        if (inst_valid !== 1'b0) begin
            report_mismatch("inst_valid_o", PC_W'(inst_valid), PC_W'(0));
        end
        rst <= 1'b0;

        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
            if (row_err != 0) begin
                tests_failed++;
            end
            $display("test %0d %s: %s, %0d instructions checked", r, name_tbl[r],
                     (row_err == 0) ? "pass" : "fail", row_got);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 NROWS, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/frontend_top.sv
`timescale 1ns/100ps

module frontend_top (
    input  logic                                  clk,
    input  logic                                  rst,

    // Backend redirect and retire
    input  logic                                  flush_i,
    input  logic [frontend_pkg::FTQ_ID_W-1:0]     flush_ftq_id_i,
    input  logic [frontend_pkg::PC_W-1:0]         redirect_pc_i,
    input  logic [frontend_pkg::COMMIT_WIDTH-1:0] commit_i,

    // Decode side
    input  logic                                  inst_ready_i,
    output logic                                  inst_valid_o,
    output logic [frontend_pkg::PC_W-1:0]         inst_pc_o,
    output logic [frontend_pkg::FTQ_ID_W-1:0]     inst_ftq_id_o,
    output logic                                  inst_cross_line_o
);

    import frontend_pkg::*;

    // Generator to FTQ
    logic             bpu_valid;
    logic [PC_W-1:0]  bpu_start_pc;
    logic [LEN_W-1:0] bpu_length;
    logic             bpu_cross_line;
    logic             ftq_full;

    // FTQ to fetch unit
    logic                ifu_valid;
    logic [PC_W-1:0]     ifu_start_pc;
    logic [LEN_W-1:0]    ifu_length;
    logic                ifu_cross_line;
    logic [FTQ_ID_W-1:0] ifu_ftq_id;
    logic                ifu_accept;

    next_block_gen u_gen (
        .clk              (clk),
        .rst              (rst),
        .ftq_full_i       (ftq_full),
        .flush_i          (flush_i),
        .redirect_pc_i    (redirect_pc_i),
        .bpu_valid_o      (bpu_valid),
        .bpu_start_pc_o   (bpu_start_pc),
        .bpu_length_o     (bpu_length),
        .bpu_cross_line_o (bpu_cross_line)
    );

    ftq u_ftq (
        .clk              (clk),
        .rst              (rst),
        .flush_i          (flush_i),
        .flush_ftq_id_i   (flush_ftq_id_i),
        .bpu_valid_i      (bpu_valid),
        .bpu_start_pc_i   (bpu_start_pc),
        .bpu_length_i     (bpu_length),
        .bpu_cross_line_i (bpu_cross_line),
        .ftq_full_o       (ftq_full),
        .commit_i         (commit_i),
        .ifu_valid_o      (ifu_valid),
        .ifu_start_pc_o   (ifu_start_pc),
        .ifu_length_o     (ifu_length),
        .ifu_cross_line_o (ifu_cross_line),
        .ifu_ftq_id_o     (ifu_ftq_id),
        .ifu_accept_i     (ifu_accept)
    );

    fetch_unit u_ifu (
        .clk               (clk),
        .rst               (rst),
        .flush_i           (flush_i),
        .ifu_valid_i       (ifu_valid),
        .ifu_start_pc_i    (ifu_start_pc),
        .ifu_length_i      (ifu_length),
        .ifu_cross_line_i  (ifu_cross_line),
        .ifu_ftq_id_i      (ifu_ftq_id),
        .ifu_accept_o      (ifu_accept),
        .inst_ready_i      (inst_ready_i),
        .inst_valid_o      (inst_valid_o),
        .inst_pc_o         (inst_pc_o),
        .inst_ftq_id_o     (inst_ftq_id_o),
        .inst_cross_line_o (inst_cross_line_o)
    );

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              flush_i,

    // From FTQ
    input  logic                              ifu_valid_i,
    input  logic [frontend_pkg::PC_W-1:0]     ifu_start_pc_i,
    input  logic [frontend_pkg::LEN_W-1:0]    ifu_length_i,
    input  logic                              ifu_cross_line_i,
    input  logic [frontend_pkg::FTQ_ID_W-1:0] ifu_ftq_id_i,
    output logic                              ifu_accept_o,

    // To decode
    input  logic                              inst_ready_i,
    output logic                              inst_valid_o,
    output logic [frontend_pkg::PC_W-1:0]     inst_pc_o,
    output logic [frontend_pkg::FTQ_ID_W-1:0] inst_ftq_id_o,
    output logic                              inst_cross_line_o
);

    import frontend_pkg::*;

    ibuf_state_e state_q, state_d;

    // Block being expanded
    logic [PC_W-1:0]     blk_pc_q;
    logic [FTQ_ID_W-1:0] blk_id_q;
    logic                blk_cross_q;
    logic [LEN_W-1:0]    rem_q;

    // Instruction buffer ring
    logic [PC_W-1:0]     pc_mem    [IBUF_DEPTH];
    logic [FTQ_ID_W-1:0] id_mem    [IBUF_DEPTH];
    logic                cross_mem [IBUF_DEPTH];

    logic [IBUF_PTR_W-1:0] wr_ptr_q;
    logic [IBUF_PTR_W-1:0] rd_ptr_q;
    logic [IBUF_CNT_W-1:0] cnt_q;
    logic [IBUF_CNT_W-1:0] free_slots;
    logic                  wr_en;
    logic                  pop;
    logic                  can_take;

    assign wr_en        = (state_q == IB_EXPAND);
    assign inst_valid_o = (cnt_q != '0);
    assign pop          = inst_valid_o && inst_ready_i;

    // Slots not yet promised to a block, plus the one decode frees now
    assign free_slots = IBUF_CNT_W'(IBUF_DEPTH) - cnt_q - IBUF_CNT_W'(rem_q)
                        + IBUF_CNT_W'(pop);

    // New block only when idle or on the last PC of the current one
    assign can_take     = (state_q == IB_IDLE) || (wr_en && (rem_q == LEN_W'(1)));
    assign ifu_accept_o = ifu_valid_i && !flush_i && can_take
                          && (free_slots >= IBUF_CNT_W'(ifu_length_i));

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = IB_FLUSHED;
        end else begin
            case (state_q)
                IB_IDLE:    if (ifu_accept_o) state_d = IB_EXPAND;
                IB_EXPAND:  if ((rem_q == LEN_W'(1)) && !ifu_accept_o) state_d = IB_IDLE;
                IB_FLUSHED: state_d = IB_IDLE;
                default:    state_d = IB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= IB_IDLE;
            rem_q    <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            state_q <= state_d;
            if (flush_i) begin
                rem_q    <= '0;
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (ifu_accept_o) begin
                    rem_q <= ifu_length_i;
                end else if (wr_en) begin
                    rem_q <= rem_q - LEN_W'(1);
                end
                if (wr_en) wr_ptr_q <= wr_ptr_q + IBUF_PTR_W'(1);
                if (pop) rd_ptr_q <= rd_ptr_q + IBUF_PTR_W'(1);
                cnt_q <= cnt_q + IBUF_CNT_W'(wr_en) - IBUF_CNT_W'(pop);
            end
        end
    end

    // Block payload and buffer contents
    always_ff @(posedge clk) begin
        if (ifu_accept_o) begin
            blk_pc_q    <= ifu_start_pc_i;
            blk_id_q    <= ifu_ftq_id_i;
            blk_cross_q <= ifu_cross_line_i;
        end else if (wr_en) begin
            blk_pc_q <= blk_pc_q + PC_W'(4);
        end
        if (wr_en) begin
            pc_mem[wr_ptr_q]    <= blk_pc_q;
            id_mem[wr_ptr_q]    <= blk_id_q;
            cross_mem[wr_ptr_q] <= blk_cross_q;
        end
    end

    assign inst_pc_o         = pc_mem[rd_ptr_q];
    assign inst_ftq_id_o     = id_mem[rd_ptr_q];
    assign inst_cross_line_o = cross_mem[rd_ptr_q];

    // Stored plus reserved PCs fit the buffer
    a_ibuf_bound: assert property (
        @(posedge clk) disable iff (rst)
        (cnt_q + IBUF_CNT_W'(rem_q)) <= IBUF_CNT_W'(IBUF_DEPTH)
    ) else $error("fetch_unit: instruction buffer overcommitted");

endmodule

// File: hdl/ftq.sv
`timescale 1ns/100ps

module ftq (
    input  logic                                  clk,
    input  logic                                  rst,

    // Backend flush
    input  logic                                  flush_i,
    input  logic [frontend_pkg::FTQ_ID_W-1:0]     flush_ftq_id_i,

    // From block generator
    input  logic                                  bpu_valid_i,
    input  logic [frontend_pkg::PC_W-1:0]         bpu_start_pc_i,
    input  logic [frontend_pkg::LEN_W-1:0]        bpu_length_i,
    input  logic                                  bpu_cross_line_i,
    output logic                                  ftq_full_o,

    // Backend retire mask
    input  logic [frontend_pkg::COMMIT_WIDTH-1:0] commit_i,

    // To fetch unit with same-cycle accept
    output logic                                  ifu_valid_o,
    output logic [frontend_pkg::PC_W-1:0]         ifu_start_pc_o,
    output logic [frontend_pkg::LEN_W-1:0]        ifu_length_o,
    output logic                                  ifu_cross_line_o,
    output logic [frontend_pkg::FTQ_ID_W-1:0]     ifu_ftq_id_o,
    input  logic                                  ifu_accept_i
);

    import frontend_pkg::*;

    // Entry storage
    logic [FTQ_SIZE-1:0] valid_q;
    logic [PC_W-1:0]     start_pc_q [FTQ_SIZE];
    logic [LEN_W-1:0]    length_q   [FTQ_SIZE];
    logic                cross_q    [FTQ_SIZE];

    logic [FTQ_ID_W-1:0]     gen_ptr_q;
    logic [FTQ_ID_W-1:0]     ifu_ptr_q;
    logic [FTQ_ID_W-1:0]     comm_ptr_q;
    logic [FTQ_ID_W-1:0]     gen_ptr_inc;
    logic [FTQ_ID_W-1:0]     restart_ptr;
    logic [COMMIT_CNT_W-1:0] commit_num;
    logic [FTQ_SIZE-1:0]     clr_mask;
    logic [FTQ_SIZE-1:0]     set_mask;

    // Number of oldest blocks retired this cycle
    always_comb begin
        commit_num = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            commit_num = commit_num + COMMIT_CNT_W'(commit_i[i]);
        end
    end

    // Retired entries starting at the commit pointer
    always_comb begin
        clr_mask = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (i < commit_num) begin
                clr_mask[comm_ptr_q + FTQ_ID_W'(i)] = 1'b1;
            end
        end
    end

    always_comb begin
        set_mask = '0;
        if (bpu_valid_i) begin
            set_mask[gen_ptr_q] = 1'b1;
        end
    end

    assign restart_ptr = flush_ftq_id_i + FTQ_ID_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= '0;
            gen_ptr_q  <= '0;
            ifu_ptr_q  <= '0;
            comm_ptr_q <= '0;
        end else begin
            // Commit keeps draining older blocks even across a flush
            comm_ptr_q <= comm_ptr_q + FTQ_ID_W'(commit_num);
            if (flush_i) begin
                valid_q   <= '0;
                gen_ptr_q <= restart_ptr;
                ifu_ptr_q <= restart_ptr;
            end else begin
                valid_q <= (valid_q & ~clr_mask) | set_mask;
                if (bpu_valid_i) begin
                    gen_ptr_q <= gen_ptr_q + FTQ_ID_W'(1);
                end
                if (ifu_accept_i) begin
                    ifu_ptr_q <= ifu_ptr_q + FTQ_ID_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bpu_valid_i) begin
            start_pc_q[gen_ptr_q] <= bpu_start_pc_i;
            length_q[gen_ptr_q]   <= bpu_length_i;
            cross_q[gen_ptr_q]    <= bpu_cross_line_i;
        end
    end

    // Entry at the IFU pointer
    assign ifu_valid_o      = valid_q[ifu_ptr_q];
    assign ifu_start_pc_o   = start_pc_q[ifu_ptr_q];
    assign ifu_length_o     = length_q[ifu_ptr_q];
    assign ifu_cross_line_o = cross_q[ifu_ptr_q];
    assign ifu_ftq_id_o     = ifu_ptr_q;

    // One slot stays empty so full and empty differ
    assign gen_ptr_inc = gen_ptr_q + FTQ_ID_W'(1);
    assign ftq_full_o  = (gen_ptr_inc == comm_ptr_q);

    // Generator must honour full
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        bpu_valid_i |-> !ftq_full_o
    ) else $error("ftq: block written while queue full");

    // Fetch unit only takes a block that is offered
    a_accept_valid: assert property (
        @(posedge clk) disable iff (rst)
        ifu_accept_i |-> ifu_valid_o
    ) else $error("ftq: accept without valid entry");

endmodule

// File: hdl/next_block_gen.sv
`timescale 1ns/100ps

module next_block_gen (
    input  logic                           clk,
    input  logic                           rst,

    // From FTQ
    input  logic                           ftq_full_i,

    // Backend redirect
    input  logic                           flush_i,
    input  logic [frontend_pkg::PC_W-1:0]  redirect_pc_i,

    // To FTQ
    output logic                           bpu_valid_o,
    output logic [frontend_pkg::PC_W-1:0]  bpu_start_pc_o,
    output logic [frontend_pkg::LEN_W-1:0] bpu_length_o,
    output logic                           bpu_cross_line_o
);

    import frontend_pkg::*;

    logic [PC_W-1:0]       pc_q;
    logic                  active_q;
    logic [WIN_WORD_W-1:0] word_ofs;
    logic [WIN_WORD_W:0]   words_left;
    logic [LEN_W-1:0]      blk_len;
    logic [LEN_W-1:0]      len_m1;
    logic [PC_W-1:0]       last_pc;
    logic [PC_W-1:0]       next_pc;

    // Position of the start PC inside its fetch window
    assign word_ofs   = pc_q[WIN_WORD_W+1:2];
    assign words_left = (WIN_WORD_W + 1)'(WIN_WORDS) - {1'b0, word_ofs};

    // Stop at the window end and at FETCH_WIDTH
    always_comb begin
        if (words_left > (WIN_WORD_W + 1)'(FETCH_WIDTH)) begin
            blk_len = LEN_W'(FETCH_WIDTH);
        end else begin
            blk_len = words_left[LEN_W-1:0];
        end
    end

    assign len_m1  = blk_len - LEN_W'(1);
    assign last_pc = pc_q + PC_W'({len_m1, 2'b00});
    assign next_pc = pc_q + PC_W'({blk_len, 2'b00});

    // Idle for one cycle after reset or flush, then one block per free cycle
    assign bpu_valid_o      = active_q && !ftq_full_i && !flush_i;
    assign bpu_start_pc_o   = pc_q;
    assign bpu_length_o     = blk_len;
    assign bpu_cross_line_o = (pc_q[PC_W-1:LINE_OFS_W] != last_pc[PC_W-1:LINE_OFS_W]);

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            pc_q     <= RESET_PC;
        end else if (flush_i) begin
            active_q <= 1'b0;
            pc_q     <= redirect_pc_i;
        end else begin
            active_q <= 1'b1;
            if (bpu_valid_o) begin
                pc_q <= next_pc;
            end
        end
    end

    // Every block the FTQ stores holds between one and FETCH_WIDTH instructions
    a_block_len: assert property (
        @(posedge clk) disable iff (rst)
        bpu_valid_o |-> (bpu_length_o != '0) && (bpu_length_o <= LEN_W'(FETCH_WIDTH))
    ) else $error("next_block_gen: illegal block length %0d", bpu_length_o);

endmodule

// File: hdl/frontend_pkg.sv
package frontend_pkg;

    // Address width
    localparam int PC_W = 32;

    // Fetch target queue geometry
    localparam int FTQ_SIZE = 8;
    localparam int FTQ_ID_W = $clog2(FTQ_SIZE);

    // Fetch block size in instructions
    localparam int FETCH_WIDTH = 4;

    // Block length ranges 1 to FETCH_WIDTH, so one extra bit
    localparam int LEN_W = $clog2(FETCH_WIDTH) + 1;

    // A block never crosses this aligned window
    localparam int FETCH_WINDOW_BYTES = 32;
    localparam int WIN_WORDS          = FETCH_WINDOW_BYTES / 4;

    // Word index inside one window
    localparam int WIN_WORD_W = $clog2(WIN_WORDS);

    // Cache line used for the cross-line flag
    localparam int CACHELINE_BYTES = 16;
    localparam int LINE_OFS_W      = $clog2(CACHELINE_BYTES);

    // Backend retire lanes
    localparam int COMMIT_WIDTH = 2;
    localparam int COMMIT_CNT_W = $clog2(COMMIT_WIDTH) + 1;

    // Instruction buffer between fetch and decode
    localparam int IBUF_DEPTH = 8;
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);
    localparam int IBUF_CNT_W = $clog2(IBUF_DEPTH) + 1;

    // First fetch address after reset
    localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;

    // Fetch unit states
    //   IB_IDLE    no block being expanded
    //   IB_EXPAND  writing one PC of the current block per cycle
    //   IB_FLUSHED dead cycle after a backend flush
    typedef enum logic [1:0] {
        IB_IDLE,
        IB_EXPAND,
        IB_FLUSHED
    } ibuf_state_e;

endpackage
